//--- source/rob_isa_pkg.sv
package rob_isa_pkg;

    // operation kinds tracked by the reorder buffer
    typedef enum logic [3:0] {
        ALU    = 4'd0,
        LUI    = 4'd1,
        AUIPC  = 4'd2,
        JAL    = 4'd3,
        BRANCH = 4'd4,
        SB     = 4'd5,
        SH     = 4'd6,
        SW     = 4'd7
    } op_t;

    // one bit per op encoding, set for the three store kinds
    localparam logic [15:0] is_store = (16'd1 << SB) | (16'd1 << SH) | (16'd1 << SW);

    // store width classes
    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_BYTE = 2'd1,
        ST_HALF = 2'd2,
        ST_WORD = 2'd3
    } st_class_t;

    function automatic st_class_t store_class(input op_t op);
        case (op)
            SB:      return ST_BYTE;
            SH:      return ST_HALF;
            SW:      return ST_WORD;
            default: return ST_NONE;
        endcase
    endfunction

    // byte lanes written for a store at the given byte offset
    function automatic logic [3:0] store_mask(input op_t op, input logic [1:0] offset);
        case (store_class(op))
            ST_BYTE: return 4'b0001 << offset;
            ST_HALF: return 4'b0011 << offset;
            ST_WORD: return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

endpackage

//--- source/rob_cfg_pkg.sv
package rob_cfg_pkg;
    import rob_isa_pkg::*;

    // buffer geometry
    localparam int ROB_DEPTH = 8;
    localparam int PTR_W = 3;
    // occupancy counters need one extra bit to reach ROB_DEPTH
    localparam int CNT_W = PTR_W + 1;
    localparam int REG_W = 5;

    typedef logic [PTR_W-1:0] rob_ptr_t;
    typedef logic [CNT_W-1:0] rob_cnt_t;
    typedef logic [REG_W-1:0] reg_addr_t;

    // issue-stage request, rd holds the data source for stores
    typedef struct packed {
        op_t       op;
        reg_addr_t rd;
        logic      pred_taken;
    } rob_alloc_t;

    // head entry as seen by the commit decode
    typedef struct packed {
        op_t       op;
        reg_addr_t rd;
        logic      pred_taken;
        logic      actual_taken;
        logic      valid;
        logic      allocated;
    } rob_head_t;

    // register file commit
    typedef struct packed {
        logic      regfile_load;
        reg_addr_t rd;
        rob_ptr_t  entry;
    } commit_t;

    // data cache store request
    typedef struct packed {
        logic       data_write;
        logic [3:0] wmask;
        reg_addr_t  st_src;
    } store_port_t;

    // tag handed back to the register file during a flush
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        rob_ptr_t  entry;
    } tag_release_t;

    // branch outcome from the branch unit
    typedef struct packed {
        logic     update;
        rob_ptr_t entry;
        logic     taken;
    } br_update_t;

endpackage

//--- source/rob_entries.sv
`timescale 1ns/10ps

module rob_entries
    import rob_isa_pkg::*;
    import rob_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // allocation at the tail
    input  logic                 alloc_en,
    input  rob_alloc_t           alloc,
    input  rob_ptr_t             tail_ptr,
    // completion from the reservation stations
    input  logic [ROB_DEPTH-1:0] set_valid,
    input  br_update_t           br_update,
    // retire at the head
    input  logic                 retire_en,
    input  rob_ptr_t             head_ptr,
    // flush walk
    input  logic                 flush_en,
    input  rob_ptr_t             walk_ptr,
    output rob_head_t            head,
    output op_t                  walk_op,
    output reg_addr_t            walk_rd,
    output logic [ROB_DEPTH-1:0] valid_vec,
    output logic [ROB_DEPTH-1:0] allocated_vec
);

    // payload per entry
    rob_alloc_t payload [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] actual_taken;

    // payload writes, no reset
    always_ff @(posedge clk) begin
        // new entries start as not taken
        if (alloc_en) begin
            payload[tail_ptr] <= alloc;
            actual_taken[tail_ptr] <= 1'b0;
        end
        // resolved branch outcome
        if (br_update.update) begin
            actual_taken[br_update.entry] <= br_update.taken;
        end
    end

    // control bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_vec <= '0;
            allocated_vec <= '0;
        end else begin
            // completion only counts for live entries
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (set_valid[i] && allocated_vec[i]) begin
                    valid_vec[i] <= 1'b1;
                end
            end
            // head leaves the buffer
            if (retire_en) begin
                valid_vec[head_ptr] <= 1'b0;
                allocated_vec[head_ptr] <= 1'b0;
            end
            // younger entry squashed by the walk
            if (flush_en) begin
                valid_vec[walk_ptr] <= 1'b0;
                allocated_vec[walk_ptr] <= 1'b0;
            end
            // fresh entry is allocated but not yet computed
            if (alloc_en) begin
                valid_vec[tail_ptr] <= 1'b0;
                allocated_vec[tail_ptr] <= 1'b1;
            end
        end
    end

    // head view for the decode
    always_comb begin
        head.op = payload[head_ptr].op;
        head.rd = payload[head_ptr].rd;
        head.pred_taken = payload[head_ptr].pred_taken;
        head.actual_taken = actual_taken[head_ptr];
        head.valid = valid_vec[head_ptr];
        head.allocated = allocated_vec[head_ptr];
    end

    // entry under the flush walk
    assign walk_op = payload[walk_ptr].op;
    assign walk_rd = payload[walk_ptr].rd;

endmodule

//--- source/branch_queue.sv
`timescale 1ns/10ps

module branch_queue
    import rob_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // entry index of a newly allocated branch
    input  logic     push,
    input  rob_ptr_t push_ptr,
    // oldest branch committed
    input  logic     pop,
    // end of a flush
    input  logic     clear,
    output rob_ptr_t oldest,
    output logic     pending
);

    rob_ptr_t mem [ROB_DEPTH];
    rob_ptr_t rd_idx;
    rob_ptr_t wr_idx;
    rob_cnt_t count;

    // storage, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_idx] <= push_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            rd_idx <= '0;
            wr_idx <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_idx <= wr_idx + rob_ptr_t'(1);
            end
            if (pop) begin
                rd_idx <= rd_idx + rob_ptr_t'(1);
            end
            // push and pop together leave the count as is
            if (push && !pop) begin
                count <= count + rob_cnt_t'(1);
            end else if (pop && !push) begin
                count <= count - rob_cnt_t'(1);
            end
        end
    end

    // oldest branch still in flight
    assign oldest = mem[rd_idx];
    assign pending = (count != '0);

endmodule

//--- source/rob_commit_decode.sv
`timescale 1ns/10ps

module rob_commit_decode
    import rob_isa_pkg::*;
    import rob_cfg_pkg::*;
(
    input  rob_head_t   head,
    input  rob_ptr_t    head_ptr,
    // flush running, commit held
    input  logic        busy,
    input  logic [1:0]  memaddr_offset,
    input  logic        data_mem_resp,
    output commit_t     commit,
    output store_port_t store,
    output logic        commit_fire,
    output logic        branch_pop,
    output logic        mispredict
);

    logic can_commit;
    logic head_store;
    logic head_branch;

    // head is computed and live
    assign can_commit = head.valid && head.allocated && !busy;

    // classify the head op
    assign head_store = is_store[head.op];
    assign head_branch = (head.op == BRANCH);

    // store request held as a level until the cache answers
    always_comb begin
        store.data_write = can_commit && head_store;
        store.wmask = store_mask(head.op, memaddr_offset);
        store.st_src = head.rd;
    end

    // register commit for alu-type ops
    always_comb begin
        commit.regfile_load = can_commit && !head_store && !head_branch;
        commit.rd = head.rd;
        commit.entry = head_ptr;
    end

    // stores wait for the response, everything else commits at once
    always_comb begin
        if (head_store) begin
            commit_fire = can_commit && data_mem_resp;
        end else begin
            commit_fire = can_commit;
        end
    end

    // branch leaves the queue when it commits
    assign branch_pop = can_commit && head_branch;

    // wrong guess redirects fetch and starts the flush
    assign mispredict = branch_pop && (head.pred_taken != head.actual_taken);

endmodule

//--- source/rob_sequencer.sv
`timescale 1ns/10ps

module rob_sequencer
    import rob_isa_pkg::*;
    import rob_cfg_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    // issue side
    input  logic         rob_load,
    input  op_t          alloc_op,
    // from the commit decode
    input  logic         commit_fire,
    input  logic         mispredict,
    // entry under the walk pointer
    input  op_t          walk_op,
    input  reg_addr_t    walk_rd,
    output logic         alloc_en,
    output rob_ptr_t     tail_ptr,
    output rob_ptr_t     head_ptr,
    output rob_ptr_t     walk_ptr,
    output logic         flush_en,
    output logic         flush_in_prog,
    output logic         busy,
    output logic         rob_full,
    output logic         branch_push,
    output logic         queue_clear,
    output tag_release_t release_tag
);

    rob_cnt_t count;
    logic walk_done;

    // no allocation while full, mispredicting or flushing
    assign rob_full = (count == rob_cnt_t'(ROB_DEPTH)) || flush_in_prog || mispredict;
    assign alloc_en = rob_load && !rob_full;
    assign branch_push = alloc_en && (alloc_op == BRANCH);

    // mispredict cycle is itself the branch commit, so only the walk holds commit
    assign busy = flush_in_prog;

    // walk ends when it meets the tail
    assign walk_done = flush_in_prog && (walk_ptr == tail_ptr);
    assign flush_en = flush_in_prog && !walk_done;
    assign queue_clear = walk_done;

    // stores and branches own no register tag
    always_comb begin
        release_tag.valid = flush_en && !is_store[walk_op] && (walk_op != BRANCH);
        release_tag.rd = walk_rd;
        release_tag.entry = walk_ptr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            walk_ptr <= '0;
            count <= '0;
            flush_in_prog <= 1'b0;
        end else begin
            if (alloc_en) begin
                tail_ptr <= tail_ptr + rob_ptr_t'(1);
            end
            if (commit_fire) begin
                head_ptr <= head_ptr + rob_ptr_t'(1);
            end
            // occupancy
            if (alloc_en && !commit_fire) begin
                count <= count + rob_cnt_t'(1);
            end else if (commit_fire && !alloc_en) begin
                count <= count - rob_cnt_t'(1);
            end
            if (mispredict) begin
                // walk starts at the entry after the branch
                flush_in_prog <= 1'b1;
                walk_ptr <= head_ptr + rob_ptr_t'(1);
            end else if (flush_en) begin
                walk_ptr <= walk_ptr + rob_ptr_t'(1);
            end else if (walk_done) begin
                // buffer empty again
                flush_in_prog <= 1'b0;
                tail_ptr <= head_ptr;
                count <= '0;
            end
        end
    end

endmodule

//--- source/rob_top.sv
`timescale 1ns/10ps

module rob_top
    import rob_isa_pkg::*;
    import rob_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // issue stage
    input  logic                 rob_load,
    input  rob_alloc_t           alloc,
    // reservation stations and branch unit
    input  logic [ROB_DEPTH-1:0] set_valid,
    input  br_update_t           br_update,
    // data cache
    input  logic [1:0]           memaddr_offset,
    input  logic                 data_mem_resp,
    output commit_t              commit,
    output store_port_t          store,
    output logic                 ld_pc,
    output logic                 flush_in_prog,
    output tag_release_t         release_tag,
    output logic                 rob_full,
    output logic [ROB_DEPTH-1:0] valid_vec,
    output logic [ROB_DEPTH-1:0] allocated_vec,
    output rob_ptr_t             head_ptr,
    output rob_ptr_t             tail_ptr,
    output rob_ptr_t             br_ptr,
    output logic                 br_pending
);

    logic      alloc_en;
    logic      flush_en;
    logic      busy;
    logic      branch_push;
    logic      branch_pop;
    logic      queue_clear;
    logic      commit_fire;
    rob_ptr_t  walk_ptr;
    rob_head_t head;
    op_t       walk_op;
    reg_addr_t walk_rd;

    rob_entries entries0 (
        .clk(clk), .rst(rst),
        .alloc_en(alloc_en), .alloc(alloc), .tail_ptr(tail_ptr),
        .set_valid(set_valid), .br_update(br_update),
        .retire_en(commit_fire), .head_ptr(head_ptr),
        .flush_en(flush_en), .walk_ptr(walk_ptr),
        .head(head), .walk_op(walk_op), .walk_rd(walk_rd),
        .valid_vec(valid_vec), .allocated_vec(allocated_vec)
    );

    // oldest branch goes to the register file as br_ptr
    branch_queue br_queue0 (
        .clk(clk), .rst(rst),
        .push(branch_push), .push_ptr(tail_ptr),
        .pop(branch_pop), .clear(queue_clear),
        .oldest(br_ptr), .pending(br_pending)
    );

    // mispredict doubles as the fetch redirect ld_pc
    rob_commit_decode decode0 (
        .head(head), .head_ptr(head_ptr), .busy(busy),
        .memaddr_offset(memaddr_offset), .data_mem_resp(data_mem_resp),
        .commit(commit), .store(store), .commit_fire(commit_fire),
        .branch_pop(branch_pop), .mispredict(ld_pc)
    );

    rob_sequencer seq0 (
        .clk(clk), .rst(rst),
        .rob_load(rob_load), .alloc_op(alloc.op),
        .commit_fire(commit_fire), .mispredict(ld_pc),
        .walk_op(walk_op), .walk_rd(walk_rd),
        .alloc_en(alloc_en), .tail_ptr(tail_ptr), .head_ptr(head_ptr),
        .walk_ptr(walk_ptr), .flush_en(flush_en), .flush_in_prog(flush_in_prog),
        .busy(busy), .rob_full(rob_full), .branch_push(branch_push),
        .queue_clear(queue_clear), .release_tag(release_tag)
    );

endmodule

//--- verification/rob_tb.sv
`timescale 1ns/10ps

module rob_tb
    import rob_isa_pkg::*;
    import rob_cfg_pkg::*;
();

    // model view of one buffer entry
    typedef struct packed {
        op_t       op;
        reg_addr_t rd;
        logic      pred;
        logic      act;
        logic      valid;
        rob_ptr_t  idx;
    } ent_t;

    logic clk;
    logic rst;
    logic rob_load;
    rob_alloc_t alloc;
    logic [ROB_DEPTH-1:0] set_valid;
    br_update_t br_update;
    logic [1:0] memaddr_offset;
    logic data_mem_resp;
    commit_t commit;
    store_port_t store;
    logic ld_pc;
    logic flush_in_prog;
    tag_release_t release_tag;
    logic rob_full;
    logic [ROB_DEPTH-1:0] valid_vec;
    logic [ROB_DEPTH-1:0] allocated_vec;
    rob_ptr_t head_ptr;
    rob_ptr_t tail_ptr;
    rob_ptr_t br_ptr;
    logic br_pending;

    // reference model state
    ent_t ents[$];
    ent_t walk[$];
    // branches in flight, oldest first
    rob_ptr_t br_q[$];
    logic flushing = 1'b0;
    rob_ptr_t head_m = '0;
    rob_ptr_t tail_m = '0;
    // observed events consumed by expect lines
    logic [31:0] commit_log[$];
    logic [31:0] mask_log[$];
    logic [31:0] release_log[$];
    logic [31:0] lfsr = 32'h489a7cb8;
    int limit_cycles = 0;

    rob_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task report_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // taps 32 22 2 1
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) v = (v << 1) | next_random_bit();
        return v;
    endfunction

    // byte lanes from the op and the offset
    function automatic logic [3:0] expected_mask(input op_t op, input logic [1:0] off);
        logic [3:0] m;
        m = 4'b0000;
        if (op == SW) m = 4'b1111;
        if (op == SH) m = 4'b0011 << off;
        if (op == SB) m = 4'b0001 << off;
        return m;
    endfunction

    function automatic logic is_reg_op(input op_t op);
        return !(op inside {SB, SH, SW}) && (op != BRANCH);
    endfunction

    // cycle model sampled at the falling edge where outputs are stable
    always @(negedge clk) begin
        ent_t f;
        ent_t w;
        ent_t n;
        logic fire_ok;
        logic exp_rl;
        logic exp_dw;
        logic exp_mis;
        logic exp_full;
        logic exp_rel;
        logic [ROB_DEPTH-1:0] amask;
        logic [ROB_DEPTH-1:0] vmask;
        if (!rst) begin
            amask = '0;
            vmask = '0;
            foreach (ents[i]) amask[ents[i].idx] = 1'b1;
            foreach (walk[i]) amask[walk[i].idx] = 1'b1;
            foreach (ents[i]) vmask[ents[i].idx] = ents[i].valid;
            foreach (walk[i]) vmask[walk[i].idx] = walk[i].valid;
            f = '0;
            fire_ok = 1'b0;
            if (ents.size() > 0) begin
                f = ents[0];
                fire_ok = f.valid && !flushing;
            end
            exp_rl = fire_ok && is_reg_op(f.op);
            exp_dw = fire_ok && (f.op inside {SB, SH, SW});
            exp_mis = fire_ok && (f.op == BRANCH) && (f.pred != f.act);
            exp_full = (ents.size() == ROB_DEPTH) || flushing || exp_mis;
            check_value("commit.regfile_load", commit.regfile_load, exp_rl);
            if (exp_rl) begin
                check_value("commit.rd", commit.rd, f.rd);
                check_value("commit.entry", commit.entry, f.idx);
            end
            check_value("store.data_write", store.data_write, exp_dw);
            if (exp_dw) begin
                check_value("store.wmask", store.wmask, expected_mask(f.op, memaddr_offset));
                check_value("store.st_src", store.st_src, f.rd);
            end
            check_value("ld_pc", ld_pc, exp_mis);
            check_value("rob_full", rob_full, exp_full);
            check_value("flush_in_prog", flush_in_prog, flushing);
            check_value("head_ptr", head_ptr, head_m);
            check_value("tail_ptr", tail_ptr, tail_m);
            check_value("allocated_vec", allocated_vec, amask);
            check_value("valid_vec", valid_vec, vmask);
            // oldest branch still in flight
            check_value("br_pending", br_pending, br_q.size() != 0);
            if (br_q.size() != 0) check_value("br_ptr", br_ptr, br_q[0]);
            // one squashed entry per walk cycle before the buffer empties
            exp_rel = 1'b0;
            if (flushing) begin
                if (walk.size() > 0) begin
                    w = walk.pop_front();
                    exp_rel = is_reg_op(w.op);
                    if (exp_rel) begin
                        check_value("release_tag.rd", release_tag.rd, w.rd);
                        check_value("release_tag.entry", release_tag.entry, w.idx);
                    end
                end else begin
                    flushing = 1'b0;
                    tail_m = head_m;
                    br_q.delete();
                end
            end
            check_value("release_tag.valid", release_tag.valid, exp_rel);
            if (release_tag.valid) release_log.push_back(release_tag.rd);
            if (commit.regfile_load) commit_log.push_back(commit.rd);
            if (store.data_write && data_mem_resp) mask_log.push_back(store.wmask);
            if (fire_ok && (!exp_dw || data_mem_resp)) begin
                void'(ents.pop_front());
                head_m = head_m + rob_ptr_t'(1);
                if (f.op == BRANCH) void'(br_q.pop_front());
                if (exp_mis) begin
                    flushing = 1'b1;
                    walk = ents;
                    ents.delete();
                end
            end
            foreach (ents[j]) begin
                if (set_valid[ents[j].idx]) ents[j].valid = 1'b1;
                if (br_update.update && br_update.entry == ents[j].idx) begin
                    ents[j].act = br_update.taken;
                end
            end
            // entries waiting for the walk can still complete
            foreach (walk[j]) begin
                if (set_valid[walk[j].idx]) walk[j].valid = 1'b1;
            end
            if (rob_load && !exp_full) begin
                n = '0;
                n.op = alloc.op;
                n.rd = alloc.rd;
                n.pred = alloc.pred_taken;
                n.idx = tail_m;
                ents.push_back(n);
                if (n.op == BRANCH) br_q.push_back(tail_m);
                tail_m = tail_m + rob_ptr_t'(1);
            end
        end
    end

    task drive_alloc(input int op, input int rd, input int pred);
        @(posedge clk);
        rob_load <= 1'b1;
        alloc <= '{op_t'(op), reg_addr_t'(rd), pred[0]};
        @(posedge clk);
        rob_load <= 1'b0;
    endtask

    task complete_entry(input int e);
        @(posedge clk);
        set_valid <= ROB_DEPTH'(1) << e;
        @(posedge clk);
        set_valid <= '0;
    endtask

    // complete every open entry in random order
    task drain_entries();
        int pend[$];
        int k;
        foreach (ents[i]) if (!ents[i].valid) pend.push_back(ents[i].idx);
        while (pend.size() > 0) begin
            k = random_bits(3) % pend.size();
            complete_entry(pend[k]);
            pend.delete(k);
        end
    endtask

    task resolve_branch(input int e, input int taken);
        @(posedge clk);
        br_update <= '{1'b1, rob_ptr_t'(e), taken[0]};
        @(posedge clk);
        br_update <= '0;
    endtask

    // cache answers a random number of cycles after the request
    task respond_store(input int off);
        @(posedge clk);
        memaddr_offset <= 2'(off);
        @(negedge clk);
        while (!store.data_write) @(negedge clk);
        repeat (random_bits(3)) @(negedge clk);
        @(posedge clk);
        data_mem_resp <= 1'b1;
        @(posedge clk);
        data_mem_resp <= 1'b0;
    endtask

    task automatic expect_log(input string name, ref logic [31:0] q[$], input int fd);
        int n;
        int v;
        int code;
        int waited;
        code = $fscanf(fd, "%h", n);
        repeat (n) begin
            code = $fscanf(fd, "%h", v);
            waited = 0;
            // a chain of commits may still be retiring
            while (q.size() == 0 && waited < 2 * ROB_DEPTH) begin
                @(posedge clk);
                waited++;
            end
            if (q.size() == 0) report_failure({"missing event in the ", name, " log"});
            else check_value(name, q.pop_front(), v);
        end
    endtask

    task expect_branch(input int v);
        @(negedge clk);
        check_value("br_pending", br_pending, v != ROB_DEPTH);
        if (v != ROB_DEPTH) check_value("br_ptr", br_ptr, v);
    endtask

    initial begin
        int fd;
        int code;
        int lines;
        int a;
        int b;
        int c;
        string cmd;
        string text;
        rst = 1'b1;
        rob_load = 1'b0;
        alloc = '0;
        set_valid = '0;
        br_update = '0;
        memaddr_offset = '0;
        data_mem_resp = 1'b0;
        // size the watchdog from the test length
        fd = $fopen("verification/rob_tests.txt", "r");
        if (fd == 0) report_failure("cannot open the test file");
        lines = 0;
        while ($fgets(text, fd)) lines++;
        $fclose(fd);
        limit_cycles = lines * 24 + 500;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("verification/rob_tests.txt", "r");
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd.substr(0, 0) == "#") begin
                code = $fgets(text, fd);
            end else if (cmd == "alloc") begin
                code = $fscanf(fd, "%h %h %h", a, b, c);
                drive_alloc(a, b, c);
            end else if (cmd == "complete") begin
                code = $fscanf(fd, "%h", a);
                complete_entry(a);
            end else if (cmd == "resolve") begin
                code = $fscanf(fd, "%h %h", a, b);
                resolve_branch(a, b);
            end else if (cmd == "respond") begin
                code = $fscanf(fd, "%h", a);
                respond_store(a);
            end else if (cmd == "idle") begin
                code = $fscanf(fd, "%h", a);
                repeat (a) @(posedge clk);
            end else if (cmd == "drain") begin
                drain_entries();
            end else if (cmd == "expect") begin
                code = $fscanf(fd, "%s", text);
                if (text == "commit") expect_log("commit rd", commit_log, fd);
                else if (text == "mask") expect_log("store wmask", mask_log, fd);
                else if (text == "release") expect_log("release rd", release_log, fd);
                else if (text == "brptr") begin
                    code = $fscanf(fd, "%h", a);
                    expect_branch(a);
                end else begin
                    code = $fscanf(fd, "%h", a);
                    @(negedge clk);
                    check_value("rob_full", rob_full, a);
                end
            end else begin
                report_failure({"unknown test command ", cmd});
            end
        end
        $fclose(fd);
        repeat (8) @(posedge clk);
        if (commit_log.size() + mask_log.size() + release_log.size() != 0) begin
            report_failure("events seen that no expect line covered");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        report_failure("timeout, the tests did not finish in time");
    end

endmodule

//--- flist.f
source/rob_isa_pkg.sv
source/rob_cfg_pkg.sv
source/rob_entries.sv
source/branch_queue.sv
source/rob_commit_decode.sv
source/rob_sequencer.sv
source/rob_top.sv
verification/rob_tb.sv

//--- Bender.yml
package:
  name: rob

sources:
  - files:
      - source/rob_isa_pkg.sv
      - source/rob_cfg_pkg.sv
      - source/rob_entries.sv
      - source/branch_queue.sv
      - source/rob_commit_decode.sv
      - source/rob_sequencer.sv
      - source/rob_top.sv
  - target: test
    files:
      - verification/rob_tb.sv

//--- verification/rob_tests.txt
# command and hex arguments: alloc op rd pred | complete entry | resolve entry taken
# respond offset | idle cycles | drain | expect commit/mask/release count values, brptr p, full f
# in-order alu commits
alloc 0 1 0
alloc 1 2 0
alloc 3 3 0
alloc 2 4 0
drain
idle 4
expect commit 4 1 2 3 4
# fill the buffer, ninth load is dropped
alloc 0 5 0
alloc 0 6 0
alloc 2 7 0
alloc 0 8 0
alloc 1 9 0
alloc 0 a 0
alloc 3 b 0
alloc 0 c 0
alloc 0 d 0
expect full 1
drain
idle 4
expect commit 8 5 6 7 8 9 a b c
# stores wait for the cache
alloc 7 6 0
alloc 6 7 0
alloc 5 8 0
alloc 0 9 0
drain
respond 0
respond 2
respond 3
idle 4
expect mask 3 f c 8
expect commit 1 9
# mispredicted branch and flush walk
alloc 4 0 1
expect brptr 0
alloc 0 a 0
alloc 5 b 0
alloc 4 0 0
alloc 1 c 0
resolve 0 0
drain
idle a
expect release 2 a c
expect brptr 8
expect full 0
# correctly predicted branches
alloc 4 0 0
alloc 4 0 1
resolve 2 1
expect brptr 1
complete 1
idle 3
expect brptr 2
complete 2
idle 3
expect brptr 8
alloc 0 d 0
drain
idle 4
expect commit 1 d
